/* design/chip_defs.svh */
// Address map, pad positions and widths shared by RTL and testbench
// Pad positions are fixed, there is no programmable pin map
// UART_CLKS_PER_BIT must be at least 2
`ifndef CHIP_DEFS_SVH
`define CHIP_DEFS_SVH

// Host bus
`define ADDR_W 8
`define OFS_W 4            // Low address bits select the register
`define DATA_W 8

// MIO pads
`define NUM_MIO 12
`define NUM_GPIO 8         // GPIO bit k sits on pad k
`define MIO_UART_TX 8
`define MIO_STRAP_LO 9
`define NUM_STRAPS 3

// UART bit period in clock cycles
`define UART_CLKS_PER_BIT 4

`endif

/* design/chip_mini_top.sv */
// Small chip top with a host register port and multiplexed I/O pads
// Pads are split into in, out and output-enable; the board resolves them
// Host reads return data one cycle after the request
`timescale 1ns/1ps
`include "chip_defs.svh"

module chip_mini_top (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                req_i,
  input  logic                we_i,
  input  logic [`ADDR_W-1:0]  addr_i,
  input  logic [`DATA_W-1:0]  wdata_i,
  output logic [`DATA_W-1:0]  rdata_o,
  input  logic [`NUM_MIO-1:0] mio_i,
  output logic [`NUM_MIO-1:0] mio_o,
  output logic [`NUM_MIO-1:0] mio_oe_o
);

  reg_bus_if gpio_bus ();
  reg_bus_if uart_bus ();
  reg_bus_if strap_bus ();

  logic [`NUM_GPIO-1:0] gpio_out;
  logic [`NUM_GPIO-1:0] gpio_oe;
  logic [`NUM_GPIO-1:0] gpio_in;
  logic                 uart_tx;

  reg_xbar u_xbar (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_i     (req_i),
    .we_i      (we_i),
    .addr_i    (addr_i),
    .wdata_i   (wdata_i),
    .rdata_o   (rdata_o),
    .gpio_bus  (gpio_bus),
    .uart_bus  (uart_bus),
    .strap_bus (strap_bus)
  );

  gpio u_gpio (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .bus      (gpio_bus),
    .pad_in_i (gpio_in),
    .out_o    (gpio_out),
    .oe_o     (gpio_oe)
  );

  uart_tx u_uart_tx (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .bus   (uart_bus),
    .tx_o  (uart_tx)
  );

  pinmux u_pinmux (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .mio_i      (mio_i),
    .gpio_out_i (gpio_out),
    .gpio_oe_i  (gpio_oe),
    .uart_tx_i  (uart_tx),
    .gpio_in_o  (gpio_in),
    .mio_o      (mio_o),
    .mio_oe_o   (mio_oe_o),
    .strap_bus  (strap_bus)
  );

endmodule

/* design/chip_pkg.sv */
// Block-select and register-offset encodings for the host address
// Block select is the upper address nibble, offset the lower one
// Any block-select value not listed here is unmapped
`include "chip_defs.svh"

package chip_pkg;

  // Upper address bits
  typedef enum logic [`ADDR_W-`OFS_W-1:0] {
    BLK_GPIO  = 'd0,
    BLK_UART  = 'd1,
    BLK_STRAP = 'd2
  } blk_sel_e;

  typedef enum logic [`OFS_W-1:0] {
    GPIO_OUT = 'd0,
    GPIO_OE  = 'd1,
    GPIO_IN  = 'd2   // Read only
  } gpio_reg_e;

  typedef enum logic [`OFS_W-1:0] {
    UART_TXDATA = 'd0,  // Write only
    UART_STATUS = 'd1   // Bit 0 is busy
  } uart_reg_e;

  typedef enum logic [`OFS_W-1:0] {
    STRAP_VAL = 'd0     // Read only
  } strap_reg_e;

endpackage

/* design/gpio.sv */
// GPIO with output and output-enable registers
// Pad inputs pass a two-flop synchronizer, so GPIO_IN lags the pads
// by two cycles
`timescale 1ns/1ps
`include "chip_defs.svh"

module gpio (
  input  logic                 clk_i,
  input  logic                 rst_i,
  reg_bus_if.dev               bus,
  input  logic [`NUM_GPIO-1:0] pad_in_i,
  output logic [`NUM_GPIO-1:0] out_o,
  output logic [`NUM_GPIO-1:0] oe_o
);
  import chip_pkg::*;

  logic [`NUM_GPIO-1:0] sync_q1;
  logic [`NUM_GPIO-1:0] sync_q2;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_o <= '0;
      oe_o  <= '0;
    end else if (bus.req && bus.we) begin
      case (bus.offset)
        GPIO_OUT: out_o <= bus.wdata[`NUM_GPIO-1:0];
        GPIO_OE:  oe_o  <= bus.wdata[`NUM_GPIO-1:0];
        default:  ;                          // GPIO_IN is read only
      endcase
    end
  end

  // Input synchronizer
  always_ff @(posedge clk_i) begin
    sync_q1 <= pad_in_i;
    sync_q2 <= sync_q1;
  end

  always_comb begin
    case (bus.offset)
      GPIO_OUT: bus.rdata = `DATA_W'(out_o);
      GPIO_OE:  bus.rdata = `DATA_W'(oe_o);
      GPIO_IN:  bus.rdata = `DATA_W'(sync_q2);
      default:  bus.rdata = '0;
    endcase
  end

endmodule

/* design/pinmux.sv */
// Fixed pin map with GPIO on pads 0 to 7, UART TX on pad 8 and straps on 9 to 11
// Straps track the pads while reset is high and freeze when it drops
// The UART pad is always an output, strap pads are always inputs
`timescale 1ns/1ps
`include "chip_defs.svh"

module pinmux (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic [`NUM_MIO-1:0]  mio_i,
  input  logic [`NUM_GPIO-1:0] gpio_out_i,
  input  logic [`NUM_GPIO-1:0] gpio_oe_i,
  input  logic                 uart_tx_i,
  output logic [`NUM_GPIO-1:0] gpio_in_o,
  output logic [`NUM_MIO-1:0]  mio_o,
  output logic [`NUM_MIO-1:0]  mio_oe_o,
  reg_bus_if.dev               strap_bus
);
  import chip_pkg::*;

  logic [`NUM_STRAPS-1:0] strap_q;

  always_comb begin
    mio_o    = '0;
    mio_oe_o = '0;                              // Strap pads stay inputs

    mio_o[`NUM_GPIO-1:0]    = gpio_out_i;
    mio_oe_o[`NUM_GPIO-1:0] = gpio_oe_i;

    mio_o[`MIO_UART_TX]    = uart_tx_i;
    mio_oe_o[`MIO_UART_TX] = 1'b1;
  end

  assign gpio_in_o = mio_i[`NUM_GPIO-1:0];

  // Last reset cycle wins
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      strap_q <= mio_i[`MIO_STRAP_LO +: `NUM_STRAPS];
    end
  end

  // Writes are ignored as the strap value is read only
  assign strap_bus.rdata = (strap_bus.offset == STRAP_VAL) ? `DATA_W'(strap_q) : '0;

endmodule

/* design/reg_bus_if.sv */
// Per-block register bus with plain strobes and no handshake
// A write lands on the edge where req and we are both high
// rdata is combinational from offset and sampled by the crossbar
`timescale 1ns/1ps
`include "chip_defs.svh"

interface reg_bus_if;
  logic              req;
  logic              we;
  logic [`OFS_W-1:0] offset;
  logic [`DATA_W-1:0] wdata;
  logic [`DATA_W-1:0] rdata;

  // Crossbar side
  modport host (
    output req, we, offset, wdata,
    input  rdata
  );

  // Register block side
  modport dev (
    input  req, we, offset, wdata,
    output rdata
  );
endinterface

/* design/reg_xbar.sv */
// Address crossbar from the host port to three register blocks
// Read data is registered, so it shows one cycle after the request
// Unmapped blocks read as zero and ignore writes
`timescale 1ns/1ps
`include "chip_defs.svh"

module reg_xbar (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               req_i,
  input  logic               we_i,
  input  logic [`ADDR_W-1:0] addr_i,
  input  logic [`DATA_W-1:0] wdata_i,
  output logic [`DATA_W-1:0] rdata_o,
  reg_bus_if.host            gpio_bus,
  reg_bus_if.host            uart_bus,
  reg_bus_if.host            strap_bus
);
  import chip_pkg::*;

  logic [`ADDR_W-`OFS_W-1:0] blk;
  logic [`OFS_W-1:0]         offset;
  logic [`DATA_W-1:0]        rd_mux;

  assign blk    = addr_i[`ADDR_W-1:`OFS_W];
  assign offset = addr_i[`OFS_W-1:0];

  // Only the selected block sees the strobe
  assign gpio_bus.req  = req_i && (blk == BLK_GPIO);
  assign uart_bus.req  = req_i && (blk == BLK_UART);
  assign strap_bus.req = req_i && (blk == BLK_STRAP);

  assign gpio_bus.we      = we_i;
  assign gpio_bus.offset  = offset;
  assign gpio_bus.wdata   = wdata_i;
  assign uart_bus.we      = we_i;
  assign uart_bus.offset  = offset;
  assign uart_bus.wdata   = wdata_i;
  assign strap_bus.we     = we_i;
  assign strap_bus.offset = offset;
  assign strap_bus.wdata  = wdata_i;

  always_comb begin
    case (blk)
      BLK_GPIO:  rd_mux = gpio_bus.rdata;
      BLK_UART:  rd_mux = uart_bus.rdata;
      BLK_STRAP: rd_mux = strap_bus.rdata;
      default:   rd_mux = '0;             // Unmapped
    endcase
  end

  // Holds until the next read
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rdata_o <= '0;
    end else if (req_i && !we_i) begin
      rdata_o <= rd_mux;
    end
  end

endmodule

/* design/uart_tx.sv */
// Transmit-only 8N1 UART whose line idles high
// A TXDATA write while busy is dropped
// Busy rises on the write edge and falls at the end of the stop bit
`timescale 1ns/1ps
`include "chip_defs.svh"

module uart_tx (
  input  logic   clk_i,
  input  logic   rst_i,
  reg_bus_if.dev bus,
  output logic   tx_o
);
  import chip_pkg::*;

  localparam int CNT_W    = $clog2(`UART_CLKS_PER_BIT);
  localparam int LAST_BIT = `DATA_W + 1;  // Stop bit index

  logic [`DATA_W:0] shift_q;    // Data bits with stop bit on top
  logic [CNT_W-1:0] clk_cnt_q;
  logic [3:0]       bit_cnt_q;  // 0 start, then data, then stop
  logic             busy_q;
  logic             load;
  logic             bit_end;

  assign load    = bus.req && bus.we && (bus.offset == UART_TXDATA) && !busy_q;
  assign bit_end = (clk_cnt_q == CNT_W'(`UART_CLKS_PER_BIT - 1));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q    <= 1'b0;
      tx_o      <= 1'b1;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else if (load) begin
      busy_q    <= 1'b1;
      tx_o      <= 1'b0;                 // Start bit
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else if (busy_q) begin
      if (bit_end) begin
        clk_cnt_q <= '0;
        if (bit_cnt_q == 4'(LAST_BIT)) begin
          busy_q <= 1'b0;                // Stop bit done and the line stays high
        end else begin
          tx_o      <= shift_q[0];
          bit_cnt_q <= bit_cnt_q + 4'd1;
        end
      end else begin
        clk_cnt_q <= clk_cnt_q + 1'b1;
      end
    end
  end

  // LSB first with ones shifting in from the top
  always_ff @(posedge clk_i) begin
    if (load) begin
      shift_q <= {1'b1, bus.wdata};
    end else if (busy_q && bit_end) begin
      shift_q <= {1'b1, shift_q[`DATA_W:1]};
    end
  end

  assign bus.rdata = (bus.offset == UART_STATUS) ? `DATA_W'(busy_q) : '0;

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run tb_chip with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_chip \
    -f tb.f -Mdir obj_dir -o tb_chip_sim \
  && ./obj_dir/tb_chip_sim | tee sim.log \
  || { echo "Verilator build or simulation failed"; exit 1; }
grep -q "^TEST RESULT: PASS$" sim.log && exit 0 || exit 1

/* tb.f */
+incdir+design
design/chip_pkg.sv
design/reg_bus_if.sv
design/reg_xbar.sv
design/gpio.sv
design/uart_tx.sv
design/pinmux.sv
design/chip_mini_top.sv
testbench/tb_chip.sv

/* testbench/tb_chip.sv */
// Testbench for chip_mini_top with host register traffic and MIO pad agents
// The board drives a pad only where mio_oe_o is low
// UART line decoded on falling clock edges near the middle of each bit
`timescale 1ns/1ps
`include "chip_defs.svh"

module tb_chip;
  import chip_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RST_CYCLES   = 5;
  localparam int NUM_STEPS    = 6;
  localparam int NUM_TX_BYTES = 6;  // Five random bytes plus the drop test
  localparam int TIMEOUT_NS   = CLK_PERIOD * (200 * NUM_STEPS + 60 * NUM_TX_BYTES);

  logic clk_i, rst_i, req_i, we_i;
  logic [`ADDR_W-1:0]  addr_i;
  logic [`DATA_W-1:0]  wdata_i, rdata_o;
  logic [`NUM_MIO-1:0] mio_i, mio_o, mio_oe_o;
  logic [`NUM_MIO-1:0] pad_drv;            // Board side drivers

  logic [`NUM_GPIO-1:0]   ref_out, ref_oe;  // Register mirrors
  logic [`NUM_STRAPS-1:0] ref_strap;
  logic                   ref_busy;
  logic [7:0]             exp_bytes[$];
  logic [7:0]             rx_bytes[$];
  int                     errors;
  event                   read_done;
  logic [`ADDR_W-1:0]     rd_addr;
  logic [`DATA_W-1:0]     rd_data, rd_exp;

  chip_mini_top UUT (
    .clk_i(clk_i), .rst_i(rst_i), .req_i(req_i), .we_i(we_i), .addr_i(addr_i),
    .wdata_i(wdata_i), .rdata_o(rdata_o), .mio_i(mio_i), .mio_o(mio_o),
    .mio_oe_o(mio_oe_o)
  );

  assign mio_i = (mio_oe_o & mio_o) | (~mio_oe_o & pad_drv);  // Pad resolution

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic logic [`ADDR_W-1:0] make_addr(input logic [3:0] blk, input logic [3:0] ofs);
    return {blk, ofs};
  endfunction

  // Expected read data from the register rules
  function automatic logic [`DATA_W-1:0] ref_read(input logic [`ADDR_W-1:0] addr);
    logic [`OFS_W-1:0] ofs;
    logic [`DATA_W-1:0] val;
    ofs = addr[`OFS_W-1:0];
    val = '0;
    case (addr[`ADDR_W-1:`OFS_W])
      BLK_GPIO: begin
        if (ofs == GPIO_OUT) val = `DATA_W'(ref_out);
        if (ofs == GPIO_OE) val = `DATA_W'(ref_oe);
        if (ofs == GPIO_IN) val = `DATA_W'((ref_oe & ref_out) | (~ref_oe & pad_drv[`NUM_GPIO-1:0]));
      end
      BLK_UART:  if (ofs == UART_STATUS) val = `DATA_W'(ref_busy);
      BLK_STRAP: if (ofs == STRAP_VAL) val = `DATA_W'(ref_strap);
      default:   val = '0;                   // Unmapped block
    endcase
    return val;
  endfunction

  task automatic model_write(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
    if (addr[`ADDR_W-1:`OFS_W] == BLK_GPIO) begin
      if (addr[`OFS_W-1:0] == GPIO_OUT) ref_out = data[`NUM_GPIO-1:0];
      if (addr[`OFS_W-1:0] == GPIO_OE) ref_oe = data[`NUM_GPIO-1:0];
    end
  endtask

  task automatic host_write(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
    @(posedge clk_i);
    #2;
    req_i   = 1'b1;
    we_i    = 1'b1;
    addr_i  = addr;
    wdata_i = data;
    @(posedge clk_i);
    #2;
    req_i = 1'b0;
    we_i  = 1'b0;
    model_write(addr, data);
  endtask

  task automatic host_read(input logic [`ADDR_W-1:0] addr, output logic [`DATA_W-1:0] data);
    @(posedge clk_i);
    #2;
    req_i  = 1'b1;
    we_i   = 1'b0;
    addr_i = addr;
    @(posedge clk_i);                        // Request edge
    #2;
    req_i = 1'b0;
    @(posedge clk_i);
    #2;
    data = rdata_o;
  endtask

  task automatic read_check(input logic [`ADDR_W-1:0] addr);
    logic [`DATA_W-1:0] data;
    host_read(addr, data);
    rd_addr = addr;
    rd_data = data;
    rd_exp  = ref_read(addr);
    ->read_done;
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic wait_uart_idle();
    logic [`DATA_W-1:0] status;
    status = 8'h01;
    while (status[0]) host_read(make_addr(BLK_UART, UART_STATUS), status);
    ref_busy = 1'b0;
  endtask

  // Register read comparison
  always @(read_done) begin
    assert (rd_data === rd_exp) else begin
      errors++;
      $display("ERROR at %0t ns: read of %h gave %h, expected %h", $time, rd_addr, rd_data, rd_exp);
    end
  end

  initial begin : uart_decoder
    logic [7:0] rx;
    @(negedge rst_i);
    forever begin
      @(negedge mio_i[`MIO_UART_TX]);
      repeat (`UART_CLKS_PER_BIT / 2) @(negedge clk_i);
      check_value("UART start bit", 32'(mio_i[`MIO_UART_TX]), 0);
      for (int i = 0; i < 8; i++) begin
        repeat (`UART_CLKS_PER_BIT) @(negedge clk_i);
        rx[i] = mio_i[`MIO_UART_TX];           // LSB first
      end
      repeat (`UART_CLKS_PER_BIT) @(negedge clk_i);
      check_value("UART stop bit", 32'(mio_i[`MIO_UART_TX]), 1);
      rx_bytes.push_back(rx);
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired at %0t ns, the tests did not finish", $time);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    logic [`DATA_W-1:0] data;
    void'($urandom(32'hf636fb47));
    errors = 0;
    clk_i = 1'b0;
    rst_i = 1'b1;
    req_i = 1'b0;
    we_i = 1'b0;
    addr_i = '0;
    wdata_i = '0;
    pad_drv = '0;
    ref_out = '0;
    ref_oe = '0;
    ref_busy = 1'b0;
    // Straps move every reset cycle and the last one must stick
    for (int k = 0; k < RST_CYCLES; k++) begin
      ref_strap = `NUM_STRAPS'($urandom);
      pad_drv[`MIO_STRAP_LO +: `NUM_STRAPS] = ref_strap;
      @(posedge clk_i);
      #2;
    end
    rst_i = 1'b0;

    check_value("mio_oe_o after reset", 32'(mio_oe_o), 32'(1) << `MIO_UART_TX);
    check_value("UART pad after reset", 32'(mio_i[`MIO_UART_TX]), 1);
    read_check(make_addr(BLK_GPIO, GPIO_OUT));
    read_check(make_addr(BLK_GPIO, GPIO_OE));
    read_check(make_addr(BLK_UART, UART_STATUS));

    pad_drv[`MIO_STRAP_LO +: `NUM_STRAPS] = ref_strap ^ `NUM_STRAPS'($urandom_range(1, 7));
    repeat (3) @(posedge clk_i);
    read_check(make_addr(BLK_STRAP, STRAP_VAL));

    for (int k = 0; k < 4; k++) begin
      host_write(make_addr(BLK_GPIO, GPIO_OUT), `DATA_W'($urandom));
      host_write(make_addr(BLK_GPIO, GPIO_OE), `DATA_W'($urandom));
      check_value("GPIO pads out", 32'(mio_o[`NUM_GPIO-1:0]), 32'(ref_out));
      check_value("GPIO pads oe", 32'(mio_oe_o[`NUM_GPIO-1:0]), 32'(ref_oe));
      check_value("UART and strap oe", 32'(mio_oe_o[`NUM_MIO-1:`NUM_GPIO]), 1);
      read_check(make_addr(BLK_GPIO, GPIO_OUT));
      read_check(make_addr(BLK_GPIO, GPIO_OE));
    end

    for (int k = 0; k < 4; k++) begin
      host_write(make_addr(BLK_GPIO, GPIO_OE), (k == 0) ? '0 : `DATA_W'($urandom));
      pad_drv[`NUM_GPIO-1:0] = `NUM_GPIO'($urandom);
      repeat (3) @(posedge clk_i);
      read_check(make_addr(BLK_GPIO, GPIO_IN));
    end

    for (int k = 0; k < NUM_TX_BYTES - 1; k++) begin
      wait_uart_idle();
      data = `DATA_W'($urandom);
      host_write(make_addr(BLK_UART, UART_TXDATA), data);
      exp_bytes.push_back(data);
    end
    wait_uart_idle();
    data = `DATA_W'($urandom);
    host_write(make_addr(BLK_UART, UART_TXDATA), data);
    exp_bytes.push_back(data);
    host_write(make_addr(BLK_UART, UART_TXDATA), ~data);  // Busy, so dropped
    ref_busy = 1'b1;
    read_check(make_addr(BLK_UART, UART_STATUS));
    wait_uart_idle();
    check_value("decoded byte count", rx_bytes.size(), exp_bytes.size());
    for (int k = 0; k < exp_bytes.size() && k < rx_bytes.size(); k++) begin
      check_value("decoded UART byte", 32'(rx_bytes[k]), 32'(exp_bytes[k]));
    end

    for (int k = 0; k < 3; k++) read_check(make_addr(4'd3, 4'(k)));
    host_write(make_addr(4'd3, GPIO_OUT), `DATA_W'($urandom));
    host_write(make_addr(4'd3, GPIO_OE), `DATA_W'($urandom));
    host_write(make_addr(BLK_GPIO, GPIO_IN), `DATA_W'($urandom));
    host_write(make_addr(BLK_STRAP, STRAP_VAL), `DATA_W'($urandom));
    repeat (3) @(posedge clk_i);
    read_check(make_addr(BLK_GPIO, GPIO_OUT));
    read_check(make_addr(BLK_GPIO, GPIO_OE));
    read_check(make_addr(BLK_GPIO, GPIO_IN));
    read_check(make_addr(BLK_STRAP, STRAP_VAL));
    read_check(make_addr(4'd3, 4'd0));
    @(posedge clk_i);

    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
